// File: dv/cacheStimulus.txt
# name op adr storeWord refillLine | expected hit readWord victimDirty victimTag victimLine vk
# op 0 load 1 store 2 refill 3 invalidate-all; vk 1 compares victimTag and victimLine
miss0 0 144 00000000 00000000000000000000000000000000 0 00000000 0 00 00000000000000000000000000000000 1
miss1 0 A3F 00000000 00000000000000000000000000000000 0 00000000 0 00 00000000000000000000000000000000 1
stMs0 1 145 DEADBEEF 00000000000000000000000000000000 0 00000000 0 00 00000000000000000000000000000000 1
rfA 2 144 00000000 11111103111111021111110111111100 0 00000000 0 00 00000000000000000000000000000000 0
ldA0 0 144 00000000 00000000000000000000000000000000 1 11111100 0 00 00000000000000000000000000000000 1
ldA1 0 145 00000000 00000000000000000000000000000000 1 11111101 0 00 00000000000000000000000000000000 1
ldA2 0 146 00000000 00000000000000000000000000000000 1 11111102 0 00 00000000000000000000000000000000 1
ldA3 0 147 00000000 00000000000000000000000000000000 1 11111103 0 00 00000000000000000000000000000000 1
stMs1 1 185 CAFEF00D 00000000000000000000000000000000 0 00000000 0 00 00000000000000000000000000000000 1
ldMs1 0 185 00000000 00000000000000000000000000000000 0 00000000 0 00 00000000000000000000000000000000 1
stHit 1 146 A5A5A5A5 00000000000000000000000000000000 1 00000000 0 00 00000000000000000000000000000000 1
ldSt 0 146 00000000 00000000000000000000000000000000 1 A5A5A5A5 0 00 00000000000000000000000000000000 1
ldNb 0 147 00000000 00000000000000000000000000000000 1 11111103 0 00 00000000000000000000000000000000 1
rfW1 2 184 00000000 22222203222222022222220122222200 0 00000000 0 00 00000000000000000000000000000000 0
rfW2 2 1C4 00000000 33333303333333023333330133333300 0 00000000 0 00 00000000000000000000000000000000 0
rfW3 2 204 00000000 44444403444444024444440144444400 0 00000000 0 00 00000000000000000000000000000000 0
rfDty 2 244 00000000 55555503555555025555550155555500 0 00000000 1 05 11111103A5A5A5A51111110111111100 1
ldEv 0 146 00000000 00000000000000000000000000000000 0 00000000 0 00 00000000000000000000000000000000 1
ldW1 0 185 00000000 00000000000000000000000000000000 1 22222201 0 00 00000000000000000000000000000000 1
rf0 2 408 00000000 A0000003A0000002A0000001A0000000 0 00000000 0 00 00000000000000000000000000000000 0
rf1 2 448 00000000 B0000003B0000002B0000001B0000000 0 00000000 0 00 00000000000000000000000000000000 0
rf2 2 488 00000000 C0000003C0000002C0000001C0000000 0 00000000 0 00 00000000000000000000000000000000 0
rf3 2 4C8 00000000 D0000003D0000002D0000001D0000000 0 00000000 0 00 00000000000000000000000000000000 0
rf4 2 508 00000000 E0000003E0000002E0000001E0000000 0 00000000 0 10 A0000003A0000002A0000001A0000000 1
rf5 2 548 00000000 F0000003F0000002F0000001F0000000 0 00000000 0 11 B0000003B0000002B0000001B0000000 1
ldOld 0 408 00000000 00000000000000000000000000000000 0 00000000 0 00 00000000000000000000000000000000 1
ldC3 0 48B 00000000 00000000000000000000000000000000 1 C0000003 0 00 00000000000000000000000000000000 1
stC1 1 489 12345678 00000000000000000000000000000000 1 00000000 0 00 00000000000000000000000000000000 1
inval 3 000 00000000 00000000000000000000000000000000 0 00000000 0 00 00000000000000000000000000000000 1
ldIv1 0 185 00000000 00000000000000000000000000000000 0 00000000 0 00 00000000000000000000000000000000 1
ldIv2 0 48B 00000000 00000000000000000000000000000000 0 00000000 0 00 00000000000000000000000000000000 1
rfInv 2 588 00000000 77777703777777027777770177777700 0 00000000 0 12 C0000003C000000212345678C0000000 1
ldNew 0 58A 00000000 00000000000000000000000000000000 1 77777702 0 00 00000000000000000000000000000000 1

// File: sources.f
hw/cacheGeomPkg.sv
hw/cacheOpPkg.sv
hw/sramArray.sv
hw/cacheWay.sv
hw/cacheCtrl.sv
hw/wayMerge.sv
hw/dataCacheTop.sv
dv/dataCacheTb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the data cache testbench with Verilator, runs it and
# decides the result from the simulation output

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    -f sources.f --top-module dataCacheTb -o dataCacheSim; then
  echo "Verilator build failed"
  exit 1
fi

simOutput=$(./obj_dir/dataCacheSim)
simStatus=$?
echo "$simOutput"

if [ "$simStatus" -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if echo "$simOutput" | grep -q "TESTS PASSED"; then
  exit 0
else
  exit 1
fi

// File: dv/dataCacheTb.sv
//////////////////////////////////////////////////////////////////////
// Data cache testbench: replays request vectors from a file and
// checks each response and its 2-cycle timing against the vector
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dataCacheTb
  import cacheGeomPkg::*;
  import cacheOpPkg::*;
();

  logic      clk;
  logic      reset;
  logic      reqValid;
  cacheReqT  req;
  logic      busy;
  logic      respValid;
  cacheRespT resp;

  // Fields of the vector being replayed
  int           fd;
  int           fields;
  int           vecCount;
  string        textLine;
  string        vecName;
  logic [1:0]   opCode;
  logic [11:0]  adrIn;
  logic [31:0]  wordIn;
  logic [127:0] lineIn;
  logic         expHit;
  logic [31:0]  expWord;
  logic         expDirty;
  logic [5:0]   expTag;
  logic [127:0] expLine;
  logic         victimKnown;

  dataCacheTop dataCacheTop_i (
    .clk      (clk),
    .reset    (reset),
    .reqValid (reqValid),
    .req      (req),
    .busy     (busy),
    .respValid(respValid),
    .resp     (resp)
  );

  // 100 ns clock period
  initial clk = 1'b0;
  always #50 clk = ~clk;

  ////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////

  task automatic stopSimulation();
    $display("TESTS FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // Every value comparison of the testbench goes through here
  task automatic checkValue(input string testName, input logic [127:0] expected,
                            input logic [127:0] actual);
    if (expected !== actual) begin
      $display("FAIL %s: expected %h, actual %h", testName, expected, actual);
      stopSimulation();
    end
  endtask

  // Offers one request, waits for the response and checks it
  task automatic applyVector();
    int cycles;
    cycles = 0;
    @(posedge clk);
    #1;
    checkValue({vecName, " idle before request"}, 128'd0, 128'(busy));
    req.op       = cacheOpT'(opCode);
    req.adr      = wordAdrT'(adrIn);
    req.wordData = wordIn;
    req.lineData = lineIn;
    reqValid     = 1'b1;
    // The request is taken at this edge
    @(posedge clk);
    #1;
    reqValid = 1'b0;
    checkValue({vecName, " busy after accept"}, 128'd1, 128'(busy));
    while (!respValid) begin
      @(posedge clk);
      #1;
      cycles++;
      if (!respValid && cycles >= 10) begin
        $display("Timeout: no response to vector %s within 10 cycles", vecName);
        stopSimulation();
      end else if (!respValid) begin
        checkValue({vecName, " busy while pending"}, 128'd1, 128'(busy));
      end
    end
    // Response must come 2 cycles after acceptance with busy already low
    checkValue({vecName, " latency"}, 128'd2, 128'(cycles));
    checkValue({vecName, " busy with response"}, 128'd0, 128'(busy));
    checkValue({vecName, " hit"}, 128'(expHit), 128'(resp.hit));
    checkValue({vecName, " readWord"}, 128'(expWord), 128'(resp.readWord));
    checkValue({vecName, " victimDirty"}, 128'(expDirty), 128'(resp.victimDirty));
    // Tag and line of a never written way are unknown memory content
    if (victimKnown) begin
      checkValue({vecName, " victimTag"}, 128'(expTag), 128'(resp.victimTag));
      checkValue({vecName, " victimLine"}, expLine, 128'(resp.victimLine));
    end
    @(posedge clk);
    #1;
    checkValue({vecName, " respValid pulse"}, 128'd0, 128'(respValid));
  endtask

  ////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////

  initial begin
    reset    = 1'b1;
    reqValid = 1'b0;
    req      = '0;
    vecCount = 0;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;

    fd = $fopen("dv/cacheStimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file dv/cacheStimulus.txt");
      stopSimulation();
    end else begin
      while (!$feof(fd)) begin
        textLine = "";
        void'($fgets(textLine, fd));
        // Skip comments and empty lines
        if (textLine.len() > 1 && textLine[0] != "#") begin
          fields = $sscanf(textLine, "%s %h %h %h %h %h %h %h %h %h %h", vecName,
                           opCode, adrIn, wordIn, lineIn, expHit, expWord,
                           expDirty, expTag, expLine, victimKnown);
          if (fields != 11) begin
            $display("Stimulus line could not be parsed: %s", textLine);
            stopSimulation();
          end else begin
            applyVector();
            vecCount++;
          end
        end
      end
      $fclose(fd);
    end

    $display("Replayed %0d vectors", vecCount);
    if (vecCount > 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("No vector was replayed");
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: hw/dataCacheTop.sv
//////////////////////////////////////////////////////////////////////
// Data cache storage top: controller, four ways and the merge block
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dataCacheTop
  import cacheGeomPkg::*;
  import cacheOpPkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      reqValid,
  input  cacheReqT  req,
  output logic      busy,
  output logic      respValid,
  output cacheRespT resp
);

  wayCtrlT               ctrl;
  logic [numWays-1:0]    wayWrite;
  wayStatT [numWays-1:0] stats;
  wayIdxT                victimWay;
  wayIdxT                hitWay;
  logic                  anyHit;
  wordT                  hitWord;
  logic                  victimDirty;
  tagT                   victimTag;
  lineT                  victimLine;

  cacheCtrl cacheCtrl_i (
    .clk        (clk),
    .reset      (reset),
    .reqValid   (reqValid),
    .req        (req),
    .anyHit     (anyHit),
    .hitWay     (hitWay),
    .hitWord    (hitWord),
    .victimDirty(victimDirty),
    .victimTag  (victimTag),
    .victimLine (victimLine),
    .ctrl       (ctrl),
    .wayWrite   (wayWrite),
    .victimWay  (victimWay),
    .busy       (busy),
    .respValid  (respValid),
    .resp       (resp)
  );

  // All ways see the same control, each has its own write enable
  for (genvar w = 0; w < numWays; w++) begin : wayGen
    cacheWay cacheWay_i (
      .clk     (clk),
      .reset   (reset),
      .ctrl    (ctrl),
      .wayWrite(wayWrite[w]),
      .stat    (stats[w])
    );
  end

  wayMerge wayMerge_i (
    .stats      (stats),
    .victimWay  (victimWay),
    .wordSel    (ctrl.wordSel),
    .anyHit     (anyHit),
    .hitWay     (hitWay),
    .hitWord    (hitWord),
    .victimDirty(victimDirty),
    .victimTag  (victimTag),
    .victimLine (victimLine)
  );

endmodule

// File: hw/wayMerge.sv
//////////////////////////////////////////////////////////////////////
// Way merge: AND-OR combination of the way outputs into hit data,
// plus selection of the victim way's dirty bit, tag and line
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module wayMerge
  import cacheGeomPkg::*;
  import cacheOpPkg::*;
(
  input  wayStatT [numWays-1:0]   stats,
  input  wayIdxT                  victimWay,
  input  logic [wordSelBits-1:0]  wordSel,
  output logic                    anyHit,
  output wayIdxT                  hitWay,
  output wordT                    hitWord,
  output logic                    victimDirty,
  output tagT                     victimTag,
  output lineT                    victimLine
);

  lineT    hitLine;
  wayStatT victimStat;

  // At most one way hits, so OR-ing the masked lines acts as a mux
  always_comb begin
    anyHit  = 1'b0;
    hitWay  = '0;
    hitLine = '0;
    for (int w = 0; w < numWays; w++) begin
      anyHit  = anyHit | stats[w].hit;
      hitLine = hitLine | (stats[w].line & {$bits(lineT){stats[w].hit}});
      if (stats[w].hit) begin
        hitWay = hitWay | wayIdxT'(w);
      end
    end
  end

  // Zero on a miss since no line passes the mask
  assign hitWord = hitLine[wordSel];

  ////////////////////////////////////////////////////////////////////
  // Victim selection
  ////////////////////////////////////////////////////////////////////

  assign victimStat = stats[victimWay];

  // An invalid way holds nothing worth writing back
  assign victimDirty = victimStat.valid & victimStat.dirty;
  assign victimTag   = victimStat.tag;
  assign victimLine  = victimStat.line;

endmodule

// File: hw/cacheCtrl.sv
//////////////////////////////////////////////////////////////////////
// Cache controller: two-stage request sequencer, way write enables,
// round-robin victim pointers per set and the response register
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module cacheCtrl
  import cacheGeomPkg::*;
  import cacheOpPkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  logic                reqValid,
  input  cacheReqT            req,
  input  logic                anyHit,
  input  wayIdxT              hitWay,
  input  wordT                hitWord,
  input  logic                victimDirty,
  input  tagT                 victimTag,
  input  lineT                victimLine,
  output wayCtrlT             ctrl,
  output logic [numWays-1:0]  wayWrite,
  output wayIdxT              victimWay,
  output logic                busy,
  output logic                respValid,
  output cacheRespT           resp
);

  cacheReqT                reqQ;
  logic                    accept;
  logic                    stage1Q;
  logic                    stage2Q;
  wayIdxT [numSets-1:0]    rrPtr;
  cacheRespT               respNext;

  ////////////////////////////////////////////////////////////////////
  // Request sequencing
  ////////////////////////////////////////////////////////////////////

  // Only one request is in flight at a time
  assign busy   = stage1Q | stage2Q;
  assign accept = reqValid & ~busy;

  // Stage 1 waits for the memories, stage 2 writes and answers
  always_ff @(posedge clk) begin
    if (reset) begin
      stage1Q   <= 1'b0;
      stage2Q   <= 1'b0;
      respValid <= 1'b0;
    end else begin
      stage1Q   <= accept;
      stage2Q   <= stage1Q;
      respValid <= stage2Q;
    end
  end

  // The request stays put until the response has been registered
  always_ff @(posedge clk) begin
    if (accept) begin
      reqQ <= req;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Way control
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    ctrl.index    = reqQ.adr.index;
    ctrl.tag      = reqQ.adr.tag;
    ctrl.wordSel  = reqQ.adr.wordSel;
    ctrl.wordData = reqQ.wordData;
    ctrl.lineData = reqQ.lineData;
    // Write strobes fire only in the second stage
    ctrl.writeWord = stage2Q && (reqQ.op == opStore);
    ctrl.writeLine = stage2Q && (reqQ.op == opRefill);
    ctrl.setDirty  = stage2Q && (reqQ.op == opStore);
    ctrl.invalAll  = stage2Q && (reqQ.op == opInvalAll);
  end

  assign victimWay = rrPtr[reqQ.adr.index];

  // Store hits write the hitting way, refills the pointed victim way
  // A store miss enables no way and so leaves the cache unchanged
  always_comb begin
    wayWrite = '0;
    if (stage2Q) begin
      if (reqQ.op == opStore && anyHit) begin
        wayWrite[hitWay] = 1'b1;
      end else if (reqQ.op == opRefill) begin
        wayWrite[victimWay] = 1'b1;
      end
    end
  end

  // Each set cycles through its ways 0, 1, 2, 3 and back to 0
  always_ff @(posedge clk) begin
    if (reset) begin
      rrPtr <= '0;
    end else if (stage2Q && (reqQ.op == opRefill)) begin
      rrPtr[reqQ.adr.index] <= rrPtr[reqQ.adr.index] + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Response
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    respNext = '0;
    case (reqQ.op)
      opLoad: begin
        respNext.hit      = anyHit;
        respNext.readWord = hitWord;
      end
      opStore: begin
        respNext.hit = anyHit;
      end
      opRefill: begin
        respNext.victimDirty = victimDirty;
        respNext.victimTag   = victimTag;
        respNext.victimLine  = victimLine;
      end
      default: begin
        respNext = '0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (stage2Q) begin
      resp <= respNext;
    end
  end

endmodule

// File: hw/cacheWay.sv
//////////////////////////////////////////////////////////////////////
// One cache way: tag and word memories plus valid and dirty bits,
// reports hit and the stored line of the addressed set
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module cacheWay
  import cacheGeomPkg::*;
  import cacheOpPkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  wayCtrlT ctrl,
  input  logic    wayWrite,
  output wayStatT stat
);

  logic [numSets-1:0] validBits;
  logic [numSets-1:0] dirtyBits;
  indexT              indexQ;
  tagT                readTag;
  lineT               readLine;
  logic [lineWords-1:0] wordWe;

  // Tag memory is written only when a whole line is brought in
  sramArray #(
    .entryT(tagT),
    .depth (numSets)
  ) tagMem_i (
    .clk        (clk),
    .adr        (ctrl.index),
    .writeEnable(wayWrite & ctrl.writeLine),
    .writeData  (ctrl.tag),
    .readData   (readTag)
  );

  // One memory per word so a store touches a single word of the line
  for (genvar w = 0; w < lineWords; w++) begin : wordGen
    assign wordWe[w] = wayWrite &
                       (ctrl.writeLine | (ctrl.writeWord & (ctrl.wordSel == w)));

    sramArray #(
      .entryT(wordT),
      .depth (numSets)
    ) wordMem_i (
      .clk        (clk),
      .adr        (ctrl.index),
      .writeEnable(wordWe[w]),
      .writeData  (ctrl.writeLine ? ctrl.lineData[w] : ctrl.wordData),
      .readData   (readLine[w])
    );
  end

  // Index delayed by one cycle, aligned with the memory outputs
  always_ff @(posedge clk) begin
    indexQ <= ctrl.index;
  end

  // A refill makes the line valid and clean, a store only marks it dirty
  always_ff @(posedge clk) begin
    if (reset) begin
      validBits <= '0;
      dirtyBits <= '0;
    end else if (ctrl.invalAll) begin
      validBits <= '0;
    end else if (wayWrite) begin
      if (ctrl.writeLine) begin
        validBits[ctrl.index] <= 1'b1;
        dirtyBits[ctrl.index] <= 1'b0;
      end else if (ctrl.writeWord && ctrl.setDirty) begin
        dirtyBits[ctrl.index] <= 1'b1;
      end
    end
  end

  always_comb begin
    stat.valid = validBits[indexQ];
    stat.dirty = dirtyBits[indexQ];
    stat.tag   = readTag;
    stat.line  = readLine;
    // Tag compare against the tag held by the controller
    stat.hit   = validBits[indexQ] && (readTag == ctrl.tag);
  end

endmodule

// File: hw/sramArray.sv
//////////////////////////////////////////////////////////////////////
// Single-port memory with a registered read, entry type set by parameter
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sramArray #(
  parameter type entryT = logic [31:0],
  parameter int  depth  = 16
) (
  input  logic                     clk,
  input  logic [$clog2(depth)-1:0] adr,
  input  logic                     writeEnable,
  input  entryT                    writeData,
  output entryT                    readData
);

  entryT mem [depth];

  // A write at the same edge is passed straight to the read port,
  // so the output always shows the current content of the entry
  always_ff @(posedge clk) begin
    if (writeEnable) begin
      mem[adr] <= writeData;
      readData <= writeData;
    end else begin
      readData <= mem[adr];
    end
  end

endmodule

// File: hw/cacheOpPkg.sv
//////////////////////////////////////////////////////////////////////
// Cache operations: request and response records and the signals
// exchanged between the controller and the ways
//////////////////////////////////////////////////////////////////////

package cacheOpPkg;

  import cacheGeomPkg::*;

  typedef enum logic [1:0] {
    opLoad     = 2'd0,
    opStore    = 2'd1,
    opRefill   = 2'd2,
    opInvalAll = 2'd3
  } cacheOpT;

  // One request as seen at the cache boundary
  typedef struct packed {
    cacheOpT op;
    wordAdrT adr;
    wordT    wordData;
    lineT    lineData;
  } cacheReqT;

  // Load and store use hit and readWord, a refill fills the victim fields
  typedef struct packed {
    logic hit;
    wordT readWord;
    logic victimDirty;
    tagT  victimTag;
    lineT victimLine;
  } cacheRespT;

  // Broadcast to all ways; each way only writes when its own enable is set
  typedef struct packed {
    indexT                  index;
    tagT                    tag;
    logic [wordSelBits-1:0] wordSel;
    wordT                   wordData;
    lineT                   lineData;
    logic                   writeWord;
    logic                   writeLine;
    logic                   setDirty;
    logic                   invalAll;
  } wayCtrlT;

  // State of the addressed set in one way
  typedef struct packed {
    logic hit;
    logic valid;
    logic dirty;
    tagT  tag;
    lineT line;
  } wayStatT;

endpackage

// File: hw/cacheGeomPkg.sv
//////////////////////////////////////////////////////////////////////
// Cache geometry: sizes of sets, ways and lines, and the field types
// that split a word address into tag, set index and word select
//////////////////////////////////////////////////////////////////////

package cacheGeomPkg;

  // Organisation of the storage
  localparam int numWays   = 4;
  localparam int numSets   = 16;
  localparam int wordBits  = 32;
  localparam int lineWords = 4;

  // The address counts words, so there are no byte offset bits
  localparam int adrBits     = 12;
  localparam int indexBits   = $clog2(numSets);
  localparam int wordSelBits = $clog2(lineWords);
  localparam int tagBits     = adrBits - indexBits - wordSelBits;
  localparam int wayIdxBits  = $clog2(numWays);

  typedef logic [wordBits-1:0]   wordT;
  typedef logic [tagBits-1:0]    tagT;
  typedef logic [indexBits-1:0]  indexT;
  typedef logic [wayIdxBits-1:0] wayIdxT;

  // Word 0 of a line sits in the low bits
  typedef wordT [lineWords-1:0] lineT;

  // Tag in the upper bits, then the set, then the word within the line
  typedef struct packed {
    tagT                    tag;
    indexT                  index;
    logic [wordSelBits-1:0] wordSel;
  } wordAdrT;

endpackage
